/* design/aesCbcTop.sv */
/*
 * Top level of the AES-128 CBC core, exposing the strobe interface.
 */
`timescale 1ns/1ns

module aesCbcTop import aesPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   inValid,
  input  block_t inBlock,
  input  block_t key,
  input  logic   decrypt,
  input  logic   cbcEnable,
  output logic   busy,
  output logic   outValid,
  output block_t outBlock
);

  cbcChain i_cbcChain (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inBlock(inBlock),
    .key(key),
    .decrypt(decrypt),
    .cbcEnable(cbcEnable),
    .busy(busy),
    .outValid(outValid),
    .outBlock(outBlock)
  );

endmodule

/* design/aesIterative.sv */
/*
 * Iterative AES-128 core: key expansion, whitening, then ten rounds at one
 * per clock. done pulses for one cycle with result; result is zero otherwise.
 */
`timescale 1ns/1ns

module aesIterative import aesPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  input  block_t inBlock,
  input  block_t key,
  input  logic   decrypt,
  output logic   done,
  output block_t result
);

  localparam roundIdx_t lastRound = roundIdx_t'(NUM_ROUNDS);

  ctrlState_t stateQ;
  roundIdx_t cnt;
  roundIdx_t keyIdx;
  block_t dataReg;
  block_t keyReg;
  block_t roundKey;
  block_t roundOut;
  logic decReg;
  logic doneReg;
  logic keyStart;
  logic finalRound;

  // schedule starts one cycle after accept, from the latched key
  assign keyStart = (stateQ == Expand) && (cnt == '0);
  assign finalRound = (cnt == lastRound);

  // decryption reads the round keys backwards
  always_comb begin
    case (stateQ)
      Whiten: keyIdx = decReg ? lastRound : '0;
      Rounds: keyIdx = decReg ? lastRound - cnt : cnt;
      default: keyIdx = '0;
    endcase
  end

  aesKeyExpand i_aesKeyExpand (
    .clk(clk),
    .rst(rst),
    .start(keyStart),
    .key(keyReg),
    .keyIdx(keyIdx),
    .roundKey(roundKey)
  );

  aesRound i_aesRound (
    .state(dataReg),
    .roundKey(roundKey),
    .decrypt(decReg),
    .finalRound(finalRound),
    .next(roundOut)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      stateQ <= Idle;
      cnt <= '0;
      doneReg <= 1'b0;
    end else begin
      doneReg <= 1'b0;
      case (stateQ)
        Idle: begin
          if (start) begin
            stateQ <= Expand;
            cnt <= '0;
          end
        end
        Expand: begin
          // one cycle to load the key, ten to derive the rest
          if (cnt == lastRound) begin
            stateQ <= Whiten;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        Whiten: begin
          stateQ <= Rounds;
          cnt <= roundIdx_t'(1);
        end
        Rounds: begin
          if (finalRound) begin
            stateQ <= Idle;
            doneReg <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: stateQ <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (stateQ == Idle && start) begin
      dataReg <= inBlock;
      keyReg <= key;
      decReg <= decrypt;
    end else if (stateQ == Whiten) begin
      dataReg <= dataReg ^ roundKey;
    end else if (stateQ == Rounds) begin
      dataReg <= roundOut;
    end
  end

  assign done = doneReg;
  assign result = doneReg ? dataReg : '0;

endmodule

/* design/aesKeyExpand.sv */
/*
 * AES-128 key schedule. start stores the key as round key 0, then keys 1 to 10
 * follow one per cycle. roundKey serves the register addressed by keyIdx.
 */
`timescale 1ns/1ns

module aesKeyExpand import aesPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  block_t    key,
  input  roundIdx_t keyIdx,
  output block_t    roundKey
);

  block_t roundKeys [NUM_ROUNDS+1];
  block_t prevKey;
  block_t nextKey;
  word_t rotated;
  word_t subbed;
  word_t w0;
  word_t w1;
  word_t w2;
  word_t w3;
  roundIdx_t count;
  logic generating;
  byte_t rcon;

  // RotWord on the last word of the previous key
  assign rotated = {prevKey[23:0], prevKey[31:24]};

  for (genvar k = 0; k < 4; k++) begin : gSub
    aesSbox i_aesSbox (
      .in(rotated[BYTE_W*k +: BYTE_W]),
      .inverse(1'b0),
      .out(subbed[BYTE_W*k +: BYTE_W])
    );
  end

  assign w0 = prevKey[127:96] ^ subbed ^ {rcon, 24'h0};
  assign w1 = prevKey[95:64] ^ w0;
  assign w2 = prevKey[63:32] ^ w1;
  assign w3 = prevKey[31:0] ^ w2;
  assign nextKey = {w0, w1, w2, w3};

  always_ff @(posedge clk) begin
    if (rst) begin
      generating <= 1'b0;
      count <= '0;
      rcon <= '0;
    end else if (start) begin
      generating <= 1'b1;
      count <= roundIdx_t'(1);
      rcon <= 8'h01;
    end else if (generating) begin
      count <= count + 1'b1;
      // rcon doubles each round, 0x80 wraps to 0x1b
      rcon <= xtime(rcon);
      if (count == roundIdx_t'(NUM_ROUNDS)) begin
        generating <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      roundKeys[0] <= key;
      prevKey <= key;
    end else if (generating) begin
      roundKeys[count] <= nextKey;
      prevKey <= nextKey;
    end
  end

  assign roundKey = roundKeys[keyIdx];

endmodule

/* design/aesPkg.sv */
/*
 * Shared widths, types and the controller state for the AES-128 CBC core.
 * Every design file imports this package in its module header.
 */
package aesPkg;

  // fixed AES-128 sizes
  localparam int BLOCK_W = 128;
  localparam int BYTE_W = 8;
  localparam int NUM_ROUNDS = 10;

  typedef logic [BLOCK_W-1:0] block_t;
  typedef logic [31:0] word_t;
  typedef logic [BYTE_W-1:0] byte_t;

  // round-key index, 0 to 10
  typedef logic [3:0] roundIdx_t;

  typedef enum logic [1:0] {
    Idle,
    Expand,
    Whiten,
    Rounds
  } ctrlState_t;

  // multiply by x in GF(2^8), reduction polynomial 0x11b
  function automatic byte_t xtime(byte_t b);
    return {b[BYTE_W-2:0], 1'b0} ^ (b[BYTE_W-1] ? 8'h1b : 8'h00);
  endfunction

endpackage

/* design/aesRound.sv */
/*
 * One combinational AES round over the 128-bit state, either direction.
 * The controller registers next each cycle; finalRound drops column mixing.
 */
`timescale 1ns/1ns

module aesRound import aesPkg::*; (
  input  block_t state,
  input  block_t roundKey,
  input  logic   decrypt,
  input  logic   finalRound,
  output block_t next
);

  byte_t shifted [16];
  byte_t subbed [16];
  byte_t mixIn [16];
  byte_t by2 [16];
  byte_t by4 [16];
  byte_t by8 [16];
  byte_t mixOut [16];
  block_t subBlock;
  block_t mixInBlock;
  block_t mixBlock;

  // byte i sits at row i%4, column i/4 with byte 0 in the top bits
  // shift rows and byte substitution commute, so one order serves both directions
  for (genvar i = 0; i < 16; i++) begin : gByte
    localparam int row = i % 4;
    localparam int col = i / 4;
    localparam int encSrc = 4 * ((col + row) % 4) + row;
    localparam int decSrc = 4 * ((col + 4 - row) % 4) + row;

    assign shifted[i] = decrypt ? state[BLOCK_W-1-BYTE_W*decSrc -: BYTE_W]
                                : state[BLOCK_W-1-BYTE_W*encSrc -: BYTE_W];

    aesSbox i_aesSbox (
      .in(shifted[i]),
      .inverse(decrypt),
      .out(subbed[i])
    );

    assign subBlock[BLOCK_W-1-BYTE_W*i -: BYTE_W] = subbed[i];
  end

  // decryption adds the key before inverse mixing
  assign mixInBlock = decrypt ? (subBlock ^ roundKey) : subBlock;

  for (genvar i = 0; i < 16; i++) begin : gMul
    assign mixIn[i] = mixInBlock[BLOCK_W-1-BYTE_W*i -: BYTE_W];
    assign by2[i] = xtime(mixIn[i]);
    assign by4[i] = xtime(by2[i]);
    assign by8[i] = xtime(by4[i]);
  end

  for (genvar i = 0; i < 16; i++) begin : gMix
    localparam int row = i % 4;
    localparam int base = 4 * (i / 4);
    localparam int p0 = base + row;
    localparam int p1 = base + (row + 1) % 4;
    localparam int p2 = base + (row + 2) % 4;
    localparam int p3 = base + (row + 3) % 4;

    byte_t enc;
    byte_t dec;

    // 2 3 1 1
    assign enc = by2[p0] ^ by2[p1] ^ mixIn[p1] ^ mixIn[p2] ^ mixIn[p3];
    // 14 11 13 9
    assign dec = (by8[p0] ^ by4[p0] ^ by2[p0]) ^
                 (by8[p1] ^ by2[p1] ^ mixIn[p1]) ^
                 (by8[p2] ^ by4[p2] ^ mixIn[p2]) ^
                 (by8[p3] ^ mixIn[p3]);

    assign mixOut[i] = decrypt ? dec : enc;
    assign mixBlock[BLOCK_W-1-BYTE_W*i -: BYTE_W] = mixOut[i];
  end

  assign next = decrypt ? (finalRound ? mixInBlock : mixBlock)
                        : ((finalRound ? subBlock : mixBlock) ^ roundKey);

endmodule

/* design/aesSbox.sv */
/*
 * Computed AES S-box for one byte: GF(2^8) inverse plus affine map.
 * inverse selects the decryption S-box. Used by the round and the key schedule.
 */
`timescale 1ns/1ns

module aesSbox import aesPkg::*; (
  input  byte_t in,
  input  logic  inverse,
  output byte_t out
);

  byte_t invIn;
  byte_t gfOut;

  function automatic byte_t gfMul(byte_t a, byte_t b);
    byte_t acc;
    byte_t x;
    acc = '0;
    x = a;
    for (int i = 0; i < BYTE_W; i++) begin
      if (b[i]) begin
        acc = acc ^ x;
      end
      x = xtime(x);
    end
    return acc;
  endfunction

  // a^254 by squaring, zero stays zero
  function automatic byte_t gfInv(byte_t a);
    byte_t sq;
    byte_t acc;
    sq = a;
    acc = 8'h01;
    for (int i = 1; i < BYTE_W; i++) begin
      sq = gfMul(sq, sq);
      acc = gfMul(acc, sq);
    end
    return acc;
  endfunction

  function automatic byte_t rotl(byte_t v, int n);
    return byte_t'((v << n) | (v >> (BYTE_W - n)));
  endfunction

  function automatic byte_t affine(byte_t v);
    return v ^ rotl(v, 1) ^ rotl(v, 2) ^ rotl(v, 3) ^ rotl(v, 4) ^ 8'h63;
  endfunction

  function automatic byte_t invAffine(byte_t v);
    return rotl(v, 1) ^ rotl(v, 3) ^ rotl(v, 6) ^ 8'h05;
  endfunction

  // one inverter shared by both directions
  assign invIn = inverse ? invAffine(in) : in;
  assign gfOut = gfInv(invIn);
  assign out = inverse ? gfOut : affine(gfOut);

endmodule

/* design/cbcChain.sv */
/*
 * CBC chaining around the iterative AES core with a zero IV after reset.
 * Strobes are taken only while busy is low; results appear on outValid.
 */
`timescale 1ns/1ns

module cbcChain import aesPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   inValid,
  input  block_t inBlock,
  input  block_t key,
  input  logic   decrypt,
  input  logic   cbcEnable,
  output logic   busy,
  output logic   outValid,
  output block_t outBlock
);

  block_t chainReg;
  block_t pendingReg;
  block_t chainNext;
  block_t chainCur;
  block_t coreIn;
  block_t coreResult;
  logic coreDone;
  logic accept;
  logic busyReg;
  logic decReg;
  logic cbcReg;

  // core is idle again in its done cycle
  assign busy = busyReg && !coreDone;
  assign accept = inValid && !busy;

  // ciphertext of the finishing block, forwarded for a back-to-back accept
  assign chainNext = decReg ? pendingReg : coreResult;
  assign chainCur = coreDone ? chainNext : chainReg;

  assign coreIn = (!decrypt && cbcEnable) ? (inBlock ^ chainCur) : inBlock;

  aesIterative i_aesIterative (
    .clk(clk),
    .rst(rst),
    .start(accept),
    .inBlock(coreIn),
    .key(key),
    .decrypt(decrypt),
    .done(coreDone),
    .result(coreResult)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      busyReg <= 1'b0;
      decReg <= 1'b0;
      cbcReg <= 1'b0;
      chainReg <= '0;
      pendingReg <= '0;
    end else begin
      if (accept) begin
        busyReg <= 1'b1;
        decReg <= decrypt;
        cbcReg <= cbcEnable;
        pendingReg <= inBlock;
      end else if (coreDone) begin
        busyReg <= 1'b0;
      end
      if (coreDone) begin
        chainReg <= chainNext;
      end
    end
  end

  assign outValid = coreDone;
  assign outBlock = !coreDone ? '0 :
                    (decReg && cbcReg) ? (coreResult ^ chainReg) : coreResult;

endmodule

/* run.sh */
#!/bin/sh
# build and run the AES CBC testbench with Verilator, then scan the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aesTb -f src.f -o simAes \
  && ./obj_dir/simAes > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
exit 0

/* src.f */
design/aesPkg.sv
design/aesSbox.sv
design/aesRound.sv
design/aesKeyExpand.sv
design/aesIterative.sv
design/cbcChain.sv
design/aesCbcTop.sv
verification/aesCbcChk.sv
verification/aesTb.sv

/* verification/aesCbcChk.sv */
/*
 * Concurrent checks on the strobe interface of cbcChain, attached with bind.
 */
`timescale 1ns/1ns

module aesCbcChk import aesPkg::*; (
  input logic   clk,
  input logic   rst,
  input logic   inValid,
  input logic   busy,
  input logic   outValid,
  input block_t outBlock
);

  logic accept;

  assign accept = inValid && !busy;

  pulseWidth: assert property (@(posedge clk) disable iff (rst) outValid |=> !outValid)
    else $error("outValid held for more than one cycle");

  // accept edge, 11 expand, 1 whiten, 10 rounds
  latency: assert property (@(posedge clk) disable iff (rst)
    accept |-> ##22 !outValid ##1 outValid)
    else $error("outValid not 22 edges after the accepting edge");

  idleAfterDone: assert property (@(posedge clk) disable iff (rst)
    (outValid && !inValid) |=> !busy)
    else $error("busy high in the cycle after outValid");

  zeroWhenIdle: assert property (@(posedge clk) disable iff (rst)
    !outValid |-> outBlock == '0)
    else $error("outBlock nonzero without outValid");

endmodule

bind cbcChain aesCbcChk i_aesCbcChk (
  .clk(clk),
  .rst(rst),
  .inValid(inValid),
  .busy(busy),
  .outValid(outValid),
  .outBlock(outBlock)
);

/* verification/aesTb.sv */
/*
 * Testbench for the AES-128 CBC core: FIPS-197 vectors, random round trips,
 * CBC chaining against a scoreboard, and strobes that must be ignored while busy.
 */
`timescale 1ns/1ns

module aesTb import aesPkg::*; ();

  localparam int SEED = 35;
  localparam int TIMEOUT = 100;
  localparam int RANDOM_PAIRS = 20;
  localparam int CBC_BLOCKS = 8;
  localparam block_t FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam block_t FIPS_PT = 128'h00112233445566778899aabbccddeeff;
  localparam block_t FIPS_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic clk;
  logic rst;
  logic inValid;
  logic decrypt;
  logic cbcEnable;
  logic busy;
  logic outValid;
  block_t inBlock;
  block_t key;
  block_t outBlock;

  int errors;
  int testErrors;
  int tests;
  string testName;

  aesCbcTop i_aesCbcTop (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inBlock(inBlock),
    .key(key),
    .decrypt(decrypt),
    .cbcEnable(cbcEnable),
    .busy(busy),
    .outValid(outValid),
    .outBlock(outBlock)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic block_t randBlock();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic checkBlock(string what, block_t exp, block_t act);
    if (exp !== act) begin
      $display("FAILED %s: %s expected %h actual %h", testName, what, exp, act);
      testErrors++;
    end
  endtask

  task automatic checkFlag(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("FAILED %s: %s expected %b actual %b", testName, what, exp, act);
      testErrors++;
    end
  endtask

  task automatic finishTest();
    tests++;
    errors += testErrors;
    $display("%s: %0d mismatches", testName, testErrors);
    testErrors = 0;
  endtask

  task automatic applyReset();
    @(negedge clk);
    rst = 1'b1;
    inValid = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
  endtask

  // called on a falling edge; noisy strobes random data while the block runs
  task automatic runBlock(block_t data, block_t k, logic dec, logic cbc, logic noisy,
                          output block_t res);
    int cycles;
    int pulses;
    checkFlag("busy before strobe", 1'b0, busy);
    inValid = 1'b1;
    inBlock = data;
    key = k;
    decrypt = dec;
    cbcEnable = cbc;
    @(negedge clk);
    inValid = 1'b0;
    cycles = 0;
    while (!outValid && cycles < TIMEOUT) begin
      checkFlag("busy while running", 1'b1, busy);
      if (noisy) begin
        inValid = 1'($urandom());
        inBlock = randBlock();
        key = randBlock();
        decrypt = 1'($urandom());
        cbcEnable = 1'($urandom());
      end
      @(negedge clk);
      cycles++;
    end
    if (!outValid) begin
      $display("timeout in %s: no outValid within %0d cycles", testName, TIMEOUT);
      $display("Test failed");
      $finish;
    end else begin
      inValid = 1'b0;
      res = outBlock;
      checkFlag("busy with outValid", 1'b0, busy);
      pulses = 1;
      repeat (3) begin
        @(negedge clk);
        if (outValid) begin
          pulses++;
        end
      end
      if (pulses != 1) begin
        $display("%s: %0d outValid pulses seen for one accepted block", testName, pulses);
        testErrors++;
      end
    end
  endtask

  initial begin
    block_t res;
    block_t back;
    block_t ecb0;
    block_t p;
    block_t k;
    block_t savedPt;
    block_t savedKey;
    block_t expChain;
    block_t plain [$];
    block_t cipher [$];

    void'($urandom(SEED));
    errors = 0;
    testErrors = 0;
    tests = 0;
    rst = 1'b1;
    inValid = 1'b0;
    inBlock = '0;
    key = '0;
    decrypt = 1'b0;
    cbcEnable = 1'b0;
    applyReset();

    testName = "fips encrypt";
    checkFlag("busy after reset", 1'b0, busy);
    checkFlag("outValid after reset", 1'b0, outValid);
    runBlock(FIPS_PT, FIPS_KEY, 1'b0, 1'b0, 1'b0, res);
    checkBlock("ciphertext", FIPS_CT, res);
    finishTest();

    testName = "fips decrypt";
    runBlock(FIPS_CT, FIPS_KEY, 1'b1, 1'b0, 1'b0, res);
    checkBlock("plaintext", FIPS_PT, res);
    finishTest();

    testName = "ecb round trip";
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      p = randBlock();
      k = randBlock();
      runBlock(p, k, 1'b0, 1'b0, 1'b0, res);
      runBlock(res, k, 1'b1, 1'b0, 1'b0, back);
      checkBlock("decrypted block", p, back);
      savedPt = p;
      savedKey = k;
    end
    finishTest();

    testName = "cbc chaining";
    k = randBlock();
    for (int i = 0; i < CBC_BLOCKS; i++) begin
      plain.push_back(randBlock());
    end
    applyReset();
    runBlock(plain[0], k, 1'b0, 1'b0, 1'b0, ecb0);
    applyReset();
    expChain = '0;
    for (int i = 0; i < CBC_BLOCKS; i++) begin
      runBlock(plain[i], k, 1'b0, 1'b1, 1'b0, res);
      cipher.push_back(res);
      // a plain decrypt of the ciphertext leaves the chain at that same ciphertext
      runBlock(res, k, 1'b1, 1'b0, 1'b0, back);
      checkBlock("chained core input", plain[i] ^ expChain, back);
      expChain = res;
    end
    checkBlock("first block with zero iv", ecb0, cipher[0]);
    applyReset();
    for (int i = 0; i < CBC_BLOCKS; i++) begin
      runBlock(cipher[i], k, 1'b1, 1'b1, 1'b0, back);
      checkBlock("cbc plaintext", plain[i], back);
    end
    finishTest();

    testName = "ignored strobes";
    runBlock(FIPS_PT, FIPS_KEY, 1'b0, 1'b0, 1'b1, res);
    checkBlock("fips ciphertext", FIPS_CT, res);
    runBlock(savedPt, savedKey, 1'b0, 1'b0, 1'b1, res);
    runBlock(res, savedKey, 1'b1, 1'b0, 1'b1, back);
    checkBlock("random round trip", savedPt, back);
    runBlock(FIPS_CT, FIPS_KEY, 1'b1, 1'b0, 1'b1, res);
    checkBlock("fips plaintext", FIPS_PT, res);
    finishTest();

    $display("%0d tests run, %0d failures", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
